// ==== common/periph_consts.svh ====
// Peripheral address map and constants
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Slot field inside paddr
`define PERIPH_SLOT_LSB  12
`define PERIPH_SLOT_BITS 3

// Slot numbers, slots 4 to 7 unmapped
`define SLOT_GPIO  3'd0
`define SLOT_TIMER 3'd1
`define SLOT_EVENT 3'd2
`define SLOT_SOC   3'd3

// GPIO registers
`define GPIO_DIR     12'h000
`define GPIO_IN      12'h004
`define GPIO_OUT     12'h008
`define GPIO_INTEN   12'h00C
`define GPIO_INTSTAT 12'h010

// Timer registers
`define TIMER_COUNT 12'h000
`define TIMER_CTRL  12'h004
`define TIMER_CMP   12'h008

// Event unit registers
`define EVT_MASK    12'h000
`define EVT_PENDING 12'h004
`define EVT_CLEAR   12'h008
`define EVT_SLEEP   12'h00C

// SoC control registers
`define SOC_BOOT 12'h000
`define SOC_GATE 12'h004

// Event source bits
`define IRQ_GPIO     0
`define IRQ_TIMER    1
`define IRQ_RAM_DONE 2

// SOC_GATE bits
`define GATE_GPIO       0
`define GATE_TIMER      1
`define GATE_CPU_START  30
`define GATE_SOFT_RESET 31

// Reset values
`define BOOT_ADDR_RESET 32'h0001_0000
`define GATE_RESET      32'h0000_0003

`endif

// ==== common/apb_pkg.sv ====
// APB bus types
`include "periph_consts.svh"

package apb_pkg;

  typedef logic [31:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;
  // Peripheral slot and register offset parts of paddr
  typedef logic [`PERIPH_SLOT_BITS-1:0] apb_slot_t;
  typedef logic [`PERIPH_SLOT_LSB-1:0]  apb_off_t;

  // Master to slave, 67 bits
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // Slave to master, 34 bits
  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // Write in access phase
  function automatic logic apb_wr(apb_req_t req);
    return req.psel & req.penable & req.pwrite;
  endfunction

  // Read in access phase
  function automatic logic apb_rd(apb_req_t req);
    return req.psel & req.penable & ~req.pwrite;
  endfunction

  // Register offset seen by a peripheral
  function automatic apb_off_t apb_off(apb_req_t req);
    return req.paddr[`PERIPH_SLOT_LSB-1:0];
  endfunction

endpackage

// ==== common/periph_pkg.sv ====
// Peripheral data types
package periph_pkg;

  // One bit per pin
  typedef logic [31:0] gpio_word_t;

  // One bit per event source
  typedef logic [31:0] irq_vec_t;

  // Timer count and compare value
  typedef logic [31:0] timer_cnt_t;

  // Core sleep control
  typedef enum logic {
    CORE_RUN,
    CORE_SLEEP
  } core_state_e;

endpackage

// ==== logic/apb_decoder.sv ====
// APB slot decoder
`include "periph_consts.svh"

module apb_decoder
  import apb_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  apb_req_t req_i,
  output apb_req_t gpio_req_o,
  output apb_req_t timer_req_o,
  output apb_req_t evt_req_o,
  output apb_req_t soc_req_o,
  input  apb_rsp_t gpio_rsp_i,
  input  apb_rsp_t timer_rsp_i,
  input  apb_rsp_t evt_rsp_i,
  input  apb_rsp_t soc_rsp_i,
  output apb_rsp_t rsp_o
);

  apb_slot_t slot;

  // Slot field of the address
  assign slot = req_i.paddr[`PERIPH_SLOT_LSB +: `PERIPH_SLOT_BITS];

  // Fan out with only psel steered
  always_comb begin
    gpio_req_o       = req_i;
    timer_req_o      = req_i;
    evt_req_o        = req_i;
    soc_req_o        = req_i;
    gpio_req_o.psel  = req_i.psel & (slot == `SLOT_GPIO);
    timer_req_o.psel = req_i.psel & (slot == `SLOT_TIMER);
    evt_req_o.psel   = req_i.psel & (slot == `SLOT_EVENT);
    soc_req_o.psel   = req_i.psel & (slot == `SLOT_SOC);
  end

  // Response back from the addressed slot
  always_comb begin
    case (slot)
      `SLOT_GPIO:  rsp_o = gpio_rsp_i;
      `SLOT_TIMER: rsp_o = timer_rsp_i;
      `SLOT_EVENT: rsp_o = evt_rsp_i;
      `SLOT_SOC:   rsp_o = soc_rsp_i;
      default: begin
        // Unmapped slot answers with an error
        rsp_o.prdata  = '0;
        rsp_o.pready  = 1'b1;
        rsp_o.pslverr = 1'b1;
      end
    endcase
  end

  // Every access phase completes without wait states
  a_no_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_i.psel && req_i.penable) |-> rsp_o.pready);

endmodule

// ==== logic/gpio_unit.sv ====
// GPIO unit
`include "periph_consts.svh"

module gpio_unit
  import apb_pkg::*;
  import periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  apb_req_t   req_i,
  output apb_rsp_t   rsp_o,
  input  logic       en_i,
  input  gpio_word_t gpio_in_i,
  output gpio_word_t gpio_out_o,
  output gpio_word_t gpio_dir_o,
  output logic       irq_o
);

  gpio_word_t dir_q;
  gpio_word_t out_q;
  gpio_word_t inten_q;
  gpio_word_t intstat_q;
  gpio_word_t sync1_q;
  gpio_word_t sync2_q;
  gpio_word_t prev_q;
  gpio_word_t rise;
  logic       wr_en;
  logic       stat_clr;
  apb_off_t   off;

  assign wr_en    = apb_wr(req_i);
  assign off      = apb_off(req_i);
  // Any read of INTSTAT empties it
  assign stat_clr = apb_rd(req_i) & (off == `GPIO_INTSTAT);

  //////////////////////////////////////////////////
  // Config registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dir_q   <= '0;
      out_q   <= '0;
      inten_q <= '0;
    end else if (wr_en) begin
      case (off)
        `GPIO_DIR:   dir_q   <= req_i.pwdata;
        `GPIO_OUT:   out_q   <= req_i.pwdata;
        `GPIO_INTEN: inten_q <= req_i.pwdata;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Input sync and edge detect
  //////////////////////////////////////////////////

  // Two flops, frozen while disabled
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else if (en_i) begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  // Rising edges on enabled pins only
  assign rise = sync2_q & ~prev_q & inten_q & {$bits(gpio_word_t){en_i}};

  // New edges win over a clearing read
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      intstat_q <= '0;
    end else begin
      intstat_q <= (stat_clr ? '0 : intstat_q) | rise;
    end
  end

  // Register read mux
  always_comb begin
    rsp_o.pready  = 1'b1;
    rsp_o.pslverr = 1'b0;
    case (off)
      `GPIO_DIR:     rsp_o.prdata = dir_q;
      `GPIO_IN:      rsp_o.prdata = sync2_q;
      `GPIO_OUT:     rsp_o.prdata = out_q;
      `GPIO_INTEN:   rsp_o.prdata = inten_q;
      `GPIO_INTSTAT: rsp_o.prdata = intstat_q;
      default:       rsp_o.prdata = '0;
    endcase
  end

  assign gpio_dir_o = dir_q;
  assign gpio_out_o = out_q;
  // Level, high while any status bit set
  assign irq_o      = |intstat_q;

endmodule

// ==== timer/timer_unit.sv ====
// Compare match timer
`include "periph_consts.svh"

module timer_unit
  import apb_pkg::*;
  import periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  apb_req_t req_i,
  output apb_rsp_t rsp_o,
  input  logic     en_i,
  output logic     match_o
);

  timer_cnt_t count_q;
  timer_cnt_t cmp_q;
  logic       run_q;
  logic       match_q;
  logic       tick;
  logic       hit;
  logic       wr_en;
  apb_off_t   off;

  assign wr_en = apb_wr(req_i);
  assign off   = apb_off(req_i);

  // Count only with run bit and gate enable
  assign tick = run_q & en_i;
  assign hit  = tick & (count_q == cmp_q);

  // Control and compare registers
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_q <= 1'b0;
      cmp_q <= '1;
    end else if (wr_en) begin
      case (off)
        `TIMER_CTRL: run_q <= req_i.pwdata[0];
        `TIMER_CMP:  cmp_q <= req_i.pwdata;
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
      match_q <= 1'b0;
    end else begin
      match_q <= hit;
      // Software load beats wrap and increment
      if (wr_en && (off == `TIMER_COUNT)) begin
        count_q <= req_i.pwdata;
      end else if (hit) begin
        count_q <= '0;
      end else if (tick) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // Register read mux
  always_comb begin
    rsp_o.pready  = 1'b1;
    rsp_o.pslverr = 1'b0;
    case (off)
      `TIMER_COUNT: rsp_o.prdata = count_q;
      `TIMER_CTRL:  rsp_o.prdata = {31'b0, run_q};
      `TIMER_CMP:   rsp_o.prdata = cmp_q;
      default:      rsp_o.prdata = '0;
    endcase
  end

  // One cycle pulse after the wrap
  assign match_o = match_q;

  // Single cycle match, compare of zero matches every tick
  a_match_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (match_o && (cmp_q != '0)) |=> !match_o);

endmodule

// ==== event/event_unit.sv ====
// Event unit with core sleep control
`include "periph_consts.svh"

module event_unit
  import apb_pkg::*;
  import periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  apb_req_t req_i,
  output apb_rsp_t rsp_o,
  input  irq_vec_t src_i,
  input  logic     core_busy_i,
  output irq_vec_t irq_o,
  output logic     clk_gate_core_o
);

  irq_vec_t    mask_q;
  irq_vec_t    pend_q;
  irq_vec_t    clr;
  core_state_e state_q;
  core_state_e state_d;
  logic        sleep_req_q;
  logic        wr_en;
  apb_off_t    off;

  assign wr_en = apb_wr(req_i);
  assign off   = apb_off(req_i);
  // Ones written to CLEAR drop pending bits
  assign clr   = (wr_en && (off == `EVT_CLEAR)) ? req_i.pwdata : '0;

  //////////////////////////////////////////////////
  // Mask and pending
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mask_q <= '0;
      pend_q <= '0;
    end else begin
      if (wr_en && (off == `EVT_MASK)) begin
        mask_q <= req_i.pwdata;
      end
      // Live source sets its bit again
      pend_q <= (pend_q & ~clr) | src_i;
    end
  end

  assign irq_o = pend_q & mask_q;

  //////////////////////////////////////////////////
  // Sleep FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Wait for the core to go idle
      CORE_RUN:   if (sleep_req_q && !core_busy_i) state_d = CORE_SLEEP;
      // Any unmasked event wakes it
      CORE_SLEEP: if (|irq_o) state_d = CORE_RUN;
      default:    state_d = CORE_RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= CORE_RUN;
      sleep_req_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (wr_en && (off == `EVT_SLEEP)) begin
        sleep_req_q <= req_i.pwdata[0];
      end else if (state_d == CORE_SLEEP) begin
        sleep_req_q <= 1'b0;
      end
    end
  end

  assign clk_gate_core_o = (state_q != CORE_SLEEP);

  // Register read mux
  always_comb begin
    rsp_o.pready  = 1'b1;
    rsp_o.pslverr = 1'b0;
    case (off)
      `EVT_MASK:    rsp_o.prdata = mask_q;
      `EVT_PENDING: rsp_o.prdata = pend_q;
      `EVT_SLEEP:   rsp_o.prdata = {30'b0, sleep_req_q, state_q == CORE_SLEEP};
      default:      rsp_o.prdata = '0;
    endcase
  end

endmodule

// ==== logic/soc_ctrl.sv ====
// SoC control registers
`include "periph_consts.svh"

module soc_ctrl
  import apb_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  apb_req_t  req_i,
  output apb_rsp_t  rsp_o,
  output apb_addr_t boot_addr_o,
  output logic      gpio_en_o,
  output logic      timer_en_o,
  output logic      cpu_start_o,
  output logic      soft_reset_o
);

  apb_addr_t boot_q;
  apb_data_t gate_q;
  logic      wr_en;
  apb_off_t  off;

  assign wr_en = apb_wr(req_i);
  assign off   = apb_off(req_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      boot_q <= `BOOT_ADDR_RESET;
      gate_q <= `GATE_RESET;
    end else if (wr_en) begin
      case (off)
        `SOC_BOOT: boot_q <= req_i.pwdata;
        `SOC_GATE: gate_q <= req_i.pwdata;
        default: ;
      endcase
    end
  end

  // Both registers read back
  always_comb begin
    rsp_o.pready  = 1'b1;
    rsp_o.pslverr = 1'b0;
    case (off)
      `SOC_BOOT: rsp_o.prdata = boot_q;
      `SOC_GATE: rsp_o.prdata = gate_q;
      default:   rsp_o.prdata = '0;
    endcase
  end

  // Gate bits out to the system
  assign boot_addr_o  = boot_q;
  assign gpio_en_o    = gate_q[`GATE_GPIO];
  assign timer_en_o   = gate_q[`GATE_TIMER];
  assign cpu_start_o  = gate_q[`GATE_CPU_START];
  assign soft_reset_o = gate_q[`GATE_SOFT_RESET];

  // Core fetches from word addresses only
  a_boot_align: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    boot_addr_o[1:0] == 2'b00);

endmodule

// ==== logic/periph_subsys.sv ====
// APB peripheral subsystem top
`include "periph_consts.svh"

module periph_subsys
  import apb_pkg::*;
  import periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  apb_req_t   apb_req_i,
  output apb_rsp_t   apb_rsp_o,
  input  gpio_word_t gpio_in_i,
  output gpio_word_t gpio_out_o,
  output gpio_word_t gpio_dir_o,
  input  logic       ram_stat_done_i,
  input  logic       core_busy_i,
  output irq_vec_t   irq_o,
  output logic       clk_gate_core_o,
  output logic       soft_reset_o,
  output logic       cpu_start_o,
  output apb_addr_t  boot_addr_o
);

  apb_req_t gpio_req;
  apb_req_t timer_req;
  apb_req_t evt_req;
  apb_req_t soc_req;
  apb_rsp_t gpio_rsp;
  apb_rsp_t timer_rsp;
  apb_rsp_t evt_rsp;
  apb_rsp_t soc_rsp;
  logic     gpio_en;
  logic     timer_en;
  logic     gpio_irq;
  logic     timer_match;
  irq_vec_t evt_src;

  // Event sources by bit position
  always_comb begin
    evt_src                = '0;
    evt_src[`IRQ_GPIO]     = gpio_irq;
    evt_src[`IRQ_TIMER]    = timer_match;
    evt_src[`IRQ_RAM_DONE] = ram_stat_done_i;
  end

  //////////////////////////////////////////////////
  // Bus decode
  //////////////////////////////////////////////////

  apb_decoder apb_decoder_i (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .req_i       ( apb_req_i ),
    .gpio_req_o  ( gpio_req  ),
    .timer_req_o ( timer_req ),
    .evt_req_o   ( evt_req   ),
    .soc_req_o   ( soc_req   ),
    .gpio_rsp_i  ( gpio_rsp  ),
    .timer_rsp_i ( timer_rsp ),
    .evt_rsp_i   ( evt_rsp   ),
    .soc_rsp_i   ( soc_rsp   ),
    .rsp_o       ( apb_rsp_o )
  );

  //////////////////////////////////////////////////
  // Peripherals
  //////////////////////////////////////////////////

  gpio_unit gpio_unit_i (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .req_i      ( gpio_req   ),
    .rsp_o      ( gpio_rsp   ),
    .en_i       ( gpio_en    ),
    .gpio_in_i  ( gpio_in_i  ),
    .gpio_out_o ( gpio_out_o ),
    .gpio_dir_o ( gpio_dir_o ),
    .irq_o      ( gpio_irq   )
  );

  timer_unit timer_unit_i (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .req_i   ( timer_req   ),
    .rsp_o   ( timer_rsp   ),
    .en_i    ( timer_en    ),
    .match_o ( timer_match )
  );

  event_unit event_unit_i (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .req_i           ( evt_req         ),
    .rsp_o           ( evt_rsp         ),
    .src_i           ( evt_src         ),
    .core_busy_i     ( core_busy_i     ),
    .irq_o           ( irq_o           ),
    .clk_gate_core_o ( clk_gate_core_o )
  );

  soc_ctrl soc_ctrl_i (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .req_i        ( soc_req      ),
    .rsp_o        ( soc_rsp      ),
    .boot_addr_o  ( boot_addr_o  ),
    .gpio_en_o    ( gpio_en      ),
    .timer_en_o   ( timer_en     ),
    .cpu_start_o  ( cpu_start_o  ),
    .soft_reset_o ( soft_reset_o )
  );

endmodule

// ==== dv/tb_periph.sv ====
// Peripheral subsystem testbench
`include "periph_consts.svh"

module tb_periph
  import apb_pkg::*;
  import periph_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic       clk;
  logic       rst_n;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  gpio_word_t gpio_in;
  gpio_word_t gpio_out;
  gpio_word_t gpio_dir;
  logic       ram_done;
  logic       core_busy;
  irq_vec_t   irq;
  logic       clk_gate_core;
  logic       soft_reset;
  logic       cpu_start;
  apb_addr_t  boot_addr;

  int          errors;
  int          checks;
  logic [31:0] lfsr_q;
  // pslverr of the last transfer
  logic        last_slverr;

  periph_subsys dut_i (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .apb_req_i       ( apb_req       ),
    .apb_rsp_o       ( apb_rsp       ),
    .gpio_in_i       ( gpio_in       ),
    .gpio_out_o      ( gpio_out      ),
    .gpio_dir_o      ( gpio_dir      ),
    .ram_stat_done_i ( ram_done      ),
    .core_busy_i     ( core_busy     ),
    .irq_o           ( irq           ),
    .clk_gate_core_o ( clk_gate_core ),
    .soft_reset_o    ( soft_reset    ),
    .cpu_start_o     ( cpu_start     ),
    .boot_addr_o     ( boot_addr     )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] w;
    logic        fb;
    w = '0;
    for (int i = 0; i < nbits; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      w      = {w[30:0], fb};
    end
    return w;
  endfunction

  // Slot in bits 14:12, offset below
  function automatic apb_addr_t reg_addr(input apb_slot_t slot, input logic [11:0] off);
    return {17'b0, slot, off};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // Setup on one falling edge, access on the next
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata);
    int n;
    n = 0;
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    // Sample mid cycle, away from the clock edges
    #1;
    while (!apb_rsp.pready && n < TIMEOUT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!apb_rsp.pready) begin
      $display("APB transfer to 0x%h never saw pready", addr);
      errors++;
    end
    rdata       = apb_rsp.prdata;
    last_slverr = apb_rsp.pslverr;
    // Access phase closes on the rising edge in between
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    apb_data_t unused;
    apb_access(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
    apb_access(1'b0, addr, '0, data);
  endtask

  task automatic read_check(input apb_addr_t addr, input apb_data_t exp, input string name);
    apb_data_t data;
    apb_read(addr, data);
    check_value(name, data, exp);
  endtask

  task automatic wait_irq(input int idx, input logic val);
    int n;
    n = 0;
    while (irq[idx] !== val && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (irq[idx] !== val) begin
      $display("Timed out waiting for irq_o bit %0d to become %0b", idx, val);
      errors++;
    end
  endtask

  task automatic wait_core_gate(input logic val);
    int n;
    n = 0;
    while (clk_gate_core !== val && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (clk_gate_core !== val) begin
      $display("Timed out waiting for clk_gate_core_o to become %0b", val);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_soc_ctrl();
    apb_data_t w;
    check_value("irq_o", irq, '0);
    check_value("soft_reset_o", soft_reset, 1'b0);
    check_value("cpu_start_o", cpu_start, 1'b0);
    check_value("clk_gate_core_o", clk_gate_core, 1'b1);
    check_value("boot_addr_o", boot_addr, `BOOT_ADDR_RESET);
    read_check(reg_addr(`SLOT_SOC, `SOC_BOOT), 32'h0001_0000, "SOC_BOOT");
    read_check(reg_addr(`SLOT_SOC, `SOC_GATE), 32'h0000_0003, "SOC_GATE");
    w = rand_bits(32) & 32'hFFFF_FFFC;
    apb_write(reg_addr(`SLOT_SOC, `SOC_BOOT), w);
    check_value("boot_addr_o", boot_addr, w);
    apb_write(reg_addr(`SLOT_SOC, `SOC_GATE), 32'hC000_0003);
    check_value("cpu_start_o", cpu_start, 1'b1);
    check_value("soft_reset_o", soft_reset, 1'b1);
    // Back to the reset gate value, only outputs depend on it
    apb_write(reg_addr(`SLOT_SOC, `SOC_GATE), 32'h0000_0003);
  endtask

  task automatic test_gpio_data();
    apb_data_t w;
    w = rand_bits(32);
    apb_write(reg_addr(`SLOT_GPIO, `GPIO_DIR), w);
    check_value("gpio_dir_o", gpio_dir, w);
    w = rand_bits(32);
    apb_write(reg_addr(`SLOT_GPIO, `GPIO_OUT), w);
    check_value("gpio_out_o", gpio_out, w);
    w = rand_bits(32);
    @(negedge clk);
    gpio_in = w;
    // Two flop synchronizer
    repeat (3) @(negedge clk);
    read_check(reg_addr(`SLOT_GPIO, `GPIO_IN), w, "GPIO_IN");
    gpio_in = '0;
    repeat (4) @(negedge clk);
  endtask

  task automatic test_gpio_irq();
    logic [31:0] k;
    k = rand_bits(5);
    apb_write(reg_addr(`SLOT_GPIO, `GPIO_INTEN), 32'h1 << k);
    apb_write(reg_addr(`SLOT_EVENT, `EVT_MASK), 32'h1 << `IRQ_GPIO);
    @(negedge clk);
    gpio_in[k] = 1'b1;
    wait_irq(`IRQ_GPIO, 1'b1);
    read_check(reg_addr(`SLOT_GPIO, `GPIO_INTSTAT), 32'h1 << k, "GPIO_INTSTAT");
    // First read emptied the status
    read_check(reg_addr(`SLOT_GPIO, `GPIO_INTSTAT), 32'h0, "GPIO_INTSTAT");
    apb_write(reg_addr(`SLOT_EVENT, `EVT_CLEAR), 32'h1 << `IRQ_GPIO);
    check_value("irq_o", irq, '0);
    gpio_in = '0;
    apb_write(reg_addr(`SLOT_GPIO, `GPIO_INTEN), 32'h0);
  endtask

  task automatic test_timer();
    apb_data_t c0;
    apb_data_t c1;
    apb_write(reg_addr(`SLOT_TIMER, `TIMER_CMP), 32'd20);
    apb_write(reg_addr(`SLOT_EVENT, `EVT_MASK), 32'h1 << `IRQ_TIMER);
    apb_write(reg_addr(`SLOT_TIMER, `TIMER_CTRL), 32'h1);
    wait_irq(`IRQ_TIMER, 1'b1);
    // Drop the timer gate, count must freeze
    apb_write(reg_addr(`SLOT_SOC, `SOC_GATE), 32'h1 << `GATE_GPIO);
    apb_read(reg_addr(`SLOT_TIMER, `TIMER_COUNT), c0);
    repeat (6) @(negedge clk);
    apb_read(reg_addr(`SLOT_TIMER, `TIMER_COUNT), c1);
    check_value("TIMER_COUNT", c1, c0);
    apb_write(reg_addr(`SLOT_TIMER, `TIMER_CTRL), 32'h0);
    apb_write(reg_addr(`SLOT_SOC, `SOC_GATE), 32'h0000_0003);
    apb_write(reg_addr(`SLOT_EVENT, `EVT_CLEAR), 32'hFFFF_FFFF);
    check_value("irq_o", irq, '0);
  endtask

  task automatic test_unmapped_sleep();
    apb_data_t data;
    apb_read(reg_addr(3'd5, 12'h000), data);
    check_value("prdata", data, 32'h0);
    check_value("pslverr", last_slverr, 1'b1);
    apb_write(reg_addr(`SLOT_EVENT, `EVT_MASK), 32'h1 << `IRQ_RAM_DONE);
    // Busy core holds off the sleep request
    @(negedge clk);
    core_busy = 1'b1;
    apb_write(reg_addr(`SLOT_EVENT, `EVT_SLEEP), 32'h1);
    repeat (4) @(negedge clk);
    check_value("clk_gate_core_o", clk_gate_core, 1'b1);
    core_busy = 1'b0;
    wait_core_gate(1'b0);
    @(negedge clk);
    ram_done = 1'b1;
    wait_core_gate(1'b1);
    check_value("irq_o", irq, 32'h1 << `IRQ_RAM_DONE);
    ram_done = 1'b0;
  endtask

  initial begin
    apb_req     = '0;
    gpio_in     = '0;
    ram_done    = 1'b0;
    core_busy   = 1'b0;
    rst_n       = 1'b0;
    errors      = 0;
    checks      = 0;
    last_slverr = 1'b0;
    lfsr_q      = 32'd77231;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_soc_ctrl();
    test_gpio_data();
    test_gpio_irq();
    test_timer();
    test_unmapped_sleep();
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+common
common/apb_pkg.sv
common/periph_pkg.sv
logic/apb_decoder.sv
logic/gpio_unit.sv
timer/timer_unit.sv
event/event_unit.sv
logic/soc_ctrl.sv
logic/periph_subsys.sv
dv/tb_periph.sv

// ==== Makefile ====
TOP := tb_periph

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -Wno-fatal -f tb.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
